//--- decode_chk.sv
`default_nettype none

module decode_chk import mips_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input wire        stall,
    input wire        flush,
    input wire        out_valid,
    input op_t        op,
    input wire [4:0]  reg_w,
    input wire [31:0] imm,
    input wire        invalid
);

    int fails = 0;                          // failed assertions so far

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high after a reset edge");
            fails++;
        end

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(out_valid) && $stable(op) && $stable(reg_w)
                            && $stable(imm) && $stable(invalid))
        else begin
            $error("outputs changed while stalled");
            fails++;
        end

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else begin
            $error("out_valid high the cycle after flush");
            fails++;
        end

    // reset leaves op at OP_INVALID with invalid low, so only valid results count
    invalid_matches_op: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (invalid == (op == OP_INVALID)))
        else begin
            $error("invalid flag disagrees with op");
            fails++;
        end

endmodule

bind id_stage decode_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .out_valid (out_valid),
    .op        (op),
    .reg_w     (reg_w),
    .imm       (imm),
    .invalid   (invalid)
);

`default_nettype wire

//--- decode_if.sv
`default_nettype none

interface decode_if import mips_pkg::*; ();

    logic        claim;          // decoder owns this word
    op_t         op;
    logic [4:0]  reg_s;
    logic [4:0]  reg_t;
    logic [4:0]  dest;           // 0 when nothing is written
    logic [4:0]  shift;
    logic [25:0] imm_raw;        // imm16 or jump index
    fmt_t        fmt;
    logic        flag_unsigned;

    modport source (
        output claim,
        output op,
        output reg_s,
        output reg_t,
        output dest,
        output shift,
        output imm_raw,
        output fmt,
        output flag_unsigned
    );

    modport sink (
        input claim,
        input op,
        input reg_s,
        input reg_t,
        input dest,
        input shift,
        input imm_raw,
        input fmt,
        input flag_unsigned
    );

endinterface

`default_nettype wire

//--- decode_top.sv
`default_nettype none

module decode_top import mips_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire  [31:0] inst,
    input  wire         stall,
    input  wire         flush,
    output logic        out_valid,
    output op_t         op,
    output logic [4:0]  reg_s,
    output logic [4:0]  reg_t,
    output logic [4:0]  reg_w,
    output logic [4:0]  shift,
    output logic [31:0] imm,
    output logic        flag_unsigned,
    output logic        invalid
);

    decode_if r_bus ();                     // SPECIAL, SPECIAL2
    decode_if i_bus ();                     // imm, REGIMM, jumps

    id_r u_id_r (
        .inst (inst),
        .dec  (r_bus)
    );

    id_i u_id_i (
        .inst (inst),
        .dec  (i_bus)
    );

    id_stage u_id_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .stall         (stall),
        .flush         (flush),
        .dec_r         (r_bus),
        .dec_i         (i_bus),
        .out_valid     (out_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_w         (reg_w),
        .shift         (shift),
        .imm           (imm),
        .flag_unsigned (flag_unsigned),
        .invalid       (invalid)
    );

endmodule

`default_nettype wire

//--- filelist.f
mips_pkg.sv
decode_if.sv
id_r.sv
id_i.sv
id_stage.sv
decode_top.sv
decode_chk.sv
tb_decode.sv

//--- id_i.sv
`default_nettype none

module id_i import mips_pkg::*; (
    input  wire [31:0] inst,
    decode_if.source   dec
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic       wr_rt;
    logic       wr_link;

    assign opcode = inst[31:26];
    assign rt     = inst[20:16];

    assign dec.reg_s   = inst[25:21];
    assign dec.reg_t   = rt;
    assign dec.shift   = 5'd0;
    assign dec.imm_raw = inst[25:0];        // stage picks the width by fmt
    assign dec.dest    = wr_link ? LINK_REG : (wr_rt ? rt : 5'd0);

    always_comb begin
        dec.claim         = 1'b1;
        dec.op            = OP_INVALID;
        dec.fmt           = FMT_SIGNED_IMM;
        dec.flag_unsigned = 1'b0;
        wr_rt             = 1'b0;
        wr_link           = 1'b0;
        case (opcode)
        REGIMM: begin
            case (rt)                       // rt selects the branch
            5'h00: dec.op = OP_BLTZ;
            5'h01: dec.op = OP_BGEZ;
            5'h10: begin
                dec.op  = OP_BLTZAL;
                wr_link = 1'b1;
            end
            5'h11: begin
                dec.op  = OP_BGEZAL;
                wr_link = 1'b1;
            end
            default: dec.op = OP_INVALID;
            endcase
        end
        6'h02: begin
            dec.op  = OP_J;
            dec.fmt = FMT_JUMP;
        end
        6'h03: begin
            dec.op  = OP_JAL;
            dec.fmt = FMT_JUMP;
            wr_link = 1'b1;
        end
        6'h04: dec.op = OP_BEQ;
        6'h05: dec.op = OP_BNE;
        6'h06: dec.op = OP_BLEZ;
        6'h07: dec.op = OP_BGTZ;
        6'h08, 6'h09: begin
            dec.op            = OP_ADDI;
            dec.flag_unsigned = opcode[0];  // addiu
            wr_rt             = 1'b1;
        end
        6'h0a, 6'h0b: begin
            dec.op            = OP_SLTI;
            dec.flag_unsigned = opcode[0];  // sltiu
            wr_rt             = 1'b1;
        end
        6'h0c: begin
            dec.op  = OP_ANDI;
            dec.fmt = FMT_ZERO_IMM;
            wr_rt   = 1'b1;
        end
        6'h0d: begin
            dec.op  = OP_ORI;
            dec.fmt = FMT_ZERO_IMM;
            wr_rt   = 1'b1;
        end
        6'h0e: begin
            dec.op  = OP_XORI;
            dec.fmt = FMT_ZERO_IMM;
            wr_rt   = 1'b1;
        end
        6'h0f: begin
            dec.op  = OP_LUI;
            dec.fmt = FMT_UPPER_IMM;
            wr_rt   = 1'b1;
        end
        6'h20: begin
            dec.op = OP_LB;
            wr_rt  = 1'b1;
        end
        6'h21: begin
            dec.op = OP_LH;
            wr_rt  = 1'b1;
        end
        6'h23: begin
            dec.op = OP_LW;
            wr_rt  = 1'b1;
        end
        6'h24: begin
            dec.op            = OP_LBU;
            dec.flag_unsigned = 1'b1;
            wr_rt             = 1'b1;
        end
        6'h25: begin
            dec.op            = OP_LHU;
            dec.flag_unsigned = 1'b1;
            wr_rt             = 1'b1;
        end
        6'h28: dec.op = OP_SB;              // stores write no register
        6'h29: dec.op = OP_SH;
        6'h2b: dec.op = OP_SW;
        default: dec.claim = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- id_r.sv
`default_nettype none

module id_r import mips_pkg::*; (
    input  wire [31:0] inst,
    decode_if.source   dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       writes_rd;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    assign dec.claim   = (opcode == SPECIAL) || (opcode == SPECIAL2);
    assign dec.reg_s   = inst[25:21];
    assign dec.reg_t   = inst[20:16];
    assign dec.shift   = inst[10:6];
    assign dec.imm_raw = 26'd0;             // no immediate field
    assign dec.fmt     = FMT_NONE;
    assign dec.dest    = writes_rd ? inst[15:11] : 5'd0;

    always_comb begin
        dec.op            = OP_INVALID;
        dec.flag_unsigned = 1'b0;
        writes_rd         = 1'b1;
        if (opcode == SPECIAL) begin
            dec.flag_unsigned = funct inside {6'h19, 6'h1b, 6'h21, 6'h23, 6'h2b};
            case (funct)
            6'h00: dec.op = OP_SLL;
            6'h02: dec.op = OP_SRL;
            6'h03: dec.op = OP_SRA;
            6'h04: dec.op = OP_SLLV;
            6'h06: dec.op = OP_SRLV;
            6'h07: dec.op = OP_SRAV;
            6'h08: begin
                dec.op    = OP_JR;
                writes_rd = 1'b0;
            end
            6'h09: dec.op = OP_JALR;        // link goes to rd
            6'h0a: dec.op = OP_MOVZ;
            6'h0b: dec.op = OP_MOVN;
            6'h0c: begin
                dec.op    = OP_SYSCALL;
                writes_rd = 1'b0;
            end
            6'h10: dec.op = OP_MFHI;
            6'h11: begin
                dec.op    = OP_MTHI;
                writes_rd = 1'b0;
            end
            6'h12: dec.op = OP_MFLO;
            6'h13: begin
                dec.op    = OP_MTLO;
                writes_rd = 1'b0;
            end
            6'h18, 6'h19: begin
                dec.op    = OP_MULT;        // result in hi/lo
                writes_rd = 1'b0;
            end
            6'h1a, 6'h1b: begin
                dec.op    = OP_DIV;
                writes_rd = 1'b0;
            end
            6'h20, 6'h21: dec.op = OP_ADD;
            6'h22, 6'h23: dec.op = OP_SUB;
            6'h24: dec.op = OP_AND;
            6'h25: dec.op = OP_OR;
            6'h26: dec.op = OP_XOR;
            6'h27: dec.op = OP_NOR;
            6'h2a, 6'h2b: dec.op = OP_SLT;
            default: writes_rd = 1'b0;
            endcase
        end else if (opcode == SPECIAL2) begin
            dec.flag_unsigned = funct inside {6'h01, 6'h05};
            case (funct)
            6'h00, 6'h01: begin
                dec.op    = OP_MADD;        // accumulates into hi/lo
                writes_rd = 1'b0;
            end
            6'h02: dec.op = OP_MUL;
            6'h04, 6'h05: begin
                dec.op    = OP_MSUB;
                writes_rd = 1'b0;
            end
            6'h20: dec.op = OP_CLZ;
            6'h21: dec.op = OP_CLO;
            default: writes_rd = 1'b0;
            endcase
        end else begin
            writes_rd = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- id_stage.sv
`default_nettype none

module id_stage import mips_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire         stall,
    input  wire         flush,
    decode_if.sink      dec_r,
    decode_if.sink      dec_i,
    output logic        out_valid,
    output op_t         op,
    output logic [4:0]  reg_s,
    output logic [4:0]  reg_t,
    output logic [4:0]  reg_w,
    output logic [4:0]  shift,
    output logic [31:0] imm,
    output logic        flag_unsigned,
    output logic        invalid
);

    op_t         sel_op;
    logic [4:0]  sel_s;
    logic [4:0]  sel_t;
    logic [4:0]  sel_w;
    logic [4:0]  sel_shift;
    logic [25:0] sel_raw;
    fmt_t        sel_fmt;
    logic        sel_unsigned;
    logic [31:0] imm_ext;
    logic        take;

    // at most one decoder claims a word
    always_comb begin
        if (dec_r.claim) begin
            sel_op       = dec_r.op;
            sel_s        = dec_r.reg_s;
            sel_t        = dec_r.reg_t;
            sel_w        = dec_r.dest;
            sel_shift    = dec_r.shift;
            sel_raw      = dec_r.imm_raw;
            sel_fmt      = dec_r.fmt;
            sel_unsigned = dec_r.flag_unsigned;
        end else if (dec_i.claim) begin
            sel_op       = dec_i.op;
            sel_s        = dec_i.reg_s;
            sel_t        = dec_i.reg_t;
            sel_w        = dec_i.dest;
            sel_shift    = dec_i.shift;
            sel_raw      = dec_i.imm_raw;
            sel_fmt      = dec_i.fmt;
            sel_unsigned = dec_i.flag_unsigned;
        end else begin
            sel_op       = OP_INVALID;      // nobody owns it
            sel_s        = 5'd0;
            sel_t        = 5'd0;
            sel_w        = 5'd0;
            sel_shift    = 5'd0;
            sel_raw      = 26'd0;
            sel_fmt      = FMT_NONE;
            sel_unsigned = 1'b0;
        end
    end

    always_comb begin
        case (sel_fmt)
        FMT_SIGNED_IMM: imm_ext = {{16{sel_raw[15]}}, sel_raw[15:0]};
        FMT_ZERO_IMM:   imm_ext = {16'd0, sel_raw[15:0]};
        FMT_UPPER_IMM:  imm_ext = {sel_raw[15:0], 16'd0};  // lui
        FMT_JUMP:       imm_ext = {6'd0, sel_raw};
        default:        imm_ext = 32'd0;
        endcase
    end

    assign take = in_valid && !stall && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            op        <= OP_INVALID;
            invalid   <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;              // wins over stall
        end else if (!stall) begin
            out_valid <= in_valid;
            if (in_valid) begin
                op      <= sel_op;
                invalid <= (sel_op == OP_INVALID);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            reg_s         <= sel_s;
            reg_t         <= sel_t;
            reg_w         <= sel_w;
            shift         <= sel_shift;
            imm           <= imm_ext;
            flag_unsigned <= sel_unsigned;
        end
    end

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    // major opcodes that route to the R-type decoder or the REGIMM table
    localparam logic [5:0] SPECIAL  = 6'h00;
    localparam logic [5:0] REGIMM   = 6'h01;
    localparam logic [5:0] SPECIAL2 = 6'h1c;

    localparam logic [4:0] LINK_REG = 5'd31;  // $ra

    typedef enum logic [7:0] {
        // shifts
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLLV,
        OP_SRLV,
        OP_SRAV,
        // register jumps and moves
        OP_JR,
        OP_JALR,
        OP_MOVZ,
        OP_MOVN,
        OP_SYSCALL,
        // hi/lo unit
        OP_MFHI,
        OP_MTHI,
        OP_MFLO,
        OP_MTLO,
        OP_MULT,
        OP_DIV,
        OP_MADD,
        OP_MUL,
        OP_MSUB,
        // alu, register operands
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_CLZ,
        OP_CLO,
        // alu, immediate operand
        OP_ADDI,
        OP_SLTI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI,
        // memory
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        // branches and jumps
        OP_BEQ,
        OP_BNE,
        OP_BLEZ,
        OP_BGTZ,
        OP_BLTZ,
        OP_BGEZ,
        OP_BLTZAL,
        OP_BGEZAL,
        OP_J,
        OP_JAL,
        OP_INVALID
    } op_t;

    // five formats, so three bits
    typedef enum logic [2:0] {
        FMT_NONE,
        FMT_SIGNED_IMM,
        FMT_ZERO_IMM,
        FMT_UPPER_IMM,
        FMT_JUMP
    } fmt_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
verilator --binary --assert --top-module tb_decode -f filelist.f -o sim_decode > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_decode +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_decode.sv
`default_nettype none

module tb_decode import mips_pkg::*; ();

    localparam int STREAM_WORDS = 32;
    // reset, R table, imm forms, branches, invalid, stall/flush, drain
    localparam int TEST_CYCLES  = 6 + 38 + 14 + 10 + 13 + 100 + 6;

    localparam logic [5:0] SPECIAL_FN [29] = '{
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
        6'h0c, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h20,
        6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
    };
    localparam logic [5:0] SPECIAL2_FN [7] = '{6'h00, 6'h01, 6'h02, 6'h04, 6'h05, 6'h20, 6'h21};
    localparam logic [5:0] IMM_OPC [6]     = '{6'h08, 6'h0c, 6'h0f, 6'h23, 6'h2b, 6'h0b};
    localparam logic [4:0] REGIMM_RT [4]   = '{5'h00, 5'h01, 5'h10, 5'h11};
    localparam logic [5:0] STREAM_OPC [12] = '{
        6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h08, 6'h0c, 6'h0f, 6'h1c, 6'h23, 6'h2b, 6'h3f
    };

    typedef struct packed {
        op_t         op;
        logic [4:0]  reg_s;
        logic [4:0]  reg_t;
        logic [4:0]  reg_w;
        logic [4:0]  shift;
        logic [31:0] imm;
        logic        uns;
        logic        inv;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] inst;
    logic        stall;
    logic        flush;
    logic        out_valid;
    op_t         op;
    logic [4:0]  reg_s;
    logic [4:0]  reg_t;
    logic [4:0]  reg_w;
    logic [4:0]  shift;
    logic [31:0] imm;
    logic        flag_unsigned;
    logic        invalid;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] word_q [$];

    decode_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .inst          (inst),
        .stall         (stall),
        .flush         (flush),
        .out_valid     (out_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_w         (reg_w),
        .shift         (shift),
        .imm           (imm),
        .flag_unsigned (flag_unsigned),
        .invalid       (invalid)
    );

    always #4 clk = ~clk;

    initial begin
        #(TEST_CYCLES * 2 * 8);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // expected decode straight from the instruction set tables
    function automatic exp_t ref_decode(input logic [31:0] w);
        exp_t       e;
        logic [5:0] opc;
        logic [5:0] fn;
        logic [4:0] rt;
        opc     = w[31:26];
        fn      = w[5:0];
        rt      = w[20:16];
        e.op    = OP_INVALID;
        e.reg_s = w[25:21];
        e.reg_t = rt;
        e.reg_w = 5'd0;
        e.shift = 5'd0;
        e.imm   = 32'd0;
        e.uns   = 1'b0;
        if (opc == SPECIAL) begin
            case (fn)
            6'h00: e.op = OP_SLL;
            6'h02: e.op = OP_SRL;
            6'h03: e.op = OP_SRA;
            6'h04: e.op = OP_SLLV;
            6'h06: e.op = OP_SRLV;
            6'h07: e.op = OP_SRAV;
            6'h08: e.op = OP_JR;
            6'h09: e.op = OP_JALR;
            6'h0a: e.op = OP_MOVZ;
            6'h0b: e.op = OP_MOVN;
            6'h0c: e.op = OP_SYSCALL;
            6'h10: e.op = OP_MFHI;
            6'h11: e.op = OP_MTHI;
            6'h12: e.op = OP_MFLO;
            6'h13: e.op = OP_MTLO;
            6'h18, 6'h19: e.op = OP_MULT;
            6'h1a, 6'h1b: e.op = OP_DIV;
            6'h20, 6'h21: e.op = OP_ADD;
            6'h22, 6'h23: e.op = OP_SUB;
            6'h24: e.op = OP_AND;
            6'h25: e.op = OP_OR;
            6'h26: e.op = OP_XOR;
            6'h27: e.op = OP_NOR;
            6'h2a, 6'h2b: e.op = OP_SLT;
            default: e.op = OP_INVALID;
            endcase
            e.uns = fn inside {6'h19, 6'h1b, 6'h21, 6'h23, 6'h2b};  // multu divu addu subu sltu
        end else if (opc == SPECIAL2) begin
            case (fn)
            6'h00, 6'h01: e.op = OP_MADD;
            6'h02: e.op = OP_MUL;
            6'h04, 6'h05: e.op = OP_MSUB;
            6'h20: e.op = OP_CLZ;
            6'h21: e.op = OP_CLO;
            default: e.op = OP_INVALID;
            endcase
            e.uns = fn inside {6'h01, 6'h05};
        end else begin
            case (opc)
            REGIMM: begin
                case (rt)
                5'h00: e.op = OP_BLTZ;
                5'h01: e.op = OP_BGEZ;
                5'h10: e.op = OP_BLTZAL;
                5'h11: e.op = OP_BGEZAL;
                default: e.op = OP_INVALID;
                endcase
            end
            6'h02: e.op = OP_J;
            6'h03: e.op = OP_JAL;
            6'h04: e.op = OP_BEQ;
            6'h05: e.op = OP_BNE;
            6'h06: e.op = OP_BLEZ;
            6'h07: e.op = OP_BGTZ;
            6'h08, 6'h09: e.op = OP_ADDI;
            6'h0a, 6'h0b: e.op = OP_SLTI;
            6'h0c: e.op = OP_ANDI;
            6'h0d: e.op = OP_ORI;
            6'h0e: e.op = OP_XORI;
            6'h0f: e.op = OP_LUI;
            6'h20: e.op = OP_LB;
            6'h21: e.op = OP_LH;
            6'h23: e.op = OP_LW;
            6'h24: e.op = OP_LBU;
            6'h25: e.op = OP_LHU;
            6'h28: e.op = OP_SB;
            6'h29: e.op = OP_SH;
            6'h2b: e.op = OP_SW;
            default: e.op = OP_INVALID;
            endcase
            e.uns = opc inside {6'h09, 6'h0b, 6'h24, 6'h25};
        end
        if (opc == SPECIAL || opc == SPECIAL2) begin
            e.shift = w[10:6];                      // shamt
            if (!(e.op inside {OP_JR, OP_SYSCALL, OP_MTHI, OP_MTLO, OP_MULT, OP_DIV,
                               OP_MADD, OP_MSUB, OP_INVALID}))
                e.reg_w = w[15:11];
        end else begin
            if (e.op inside {OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                             OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU})
                e.reg_w = rt;
            else if (e.op inside {OP_JAL, OP_BLTZAL, OP_BGEZAL})
                e.reg_w = LINK_REG;
            if (e.op inside {OP_ANDI, OP_ORI, OP_XORI})
                e.imm = {16'd0, w[15:0]};
            else if (e.op == OP_LUI)
                e.imm = {w[15:0], 16'd0};
            else if (e.op inside {OP_J, OP_JAL})
                e.imm = {6'd0, w[25:0]};
            else
                e.imm = {{16{w[15]}}, w[15:0]};
        end
        e.inv = (e.op == OP_INVALID);
        return e;
    endfunction

    task automatic expect_eq(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", name, field, exp, got);
            errors++;
        end
    endtask

    task automatic check_result(input string name, input exp_t e);
        expect_eq(name, "out_valid", 32'(1), 32'(out_valid));
        expect_eq(name, "op", 32'(e.op), 32'(op));
        expect_eq(name, "reg_w", 32'(e.reg_w), 32'(reg_w));
        expect_eq(name, "flag_unsigned", 32'(e.uns), 32'(flag_unsigned));
        expect_eq(name, "invalid", 32'(e.inv), 32'(invalid));
        if (!e.inv) begin
            expect_eq(name, "imm", e.imm, imm);     // undefined for invalid words
            expect_eq(name, "shift", 32'(e.shift), 32'(shift));
            if (!(e.op inside {OP_J, OP_JAL})) begin    // jump index covers rs and rt
                expect_eq(name, "reg_s", 32'(e.reg_s), 32'(reg_s));
                expect_eq(name, "reg_t", 32'(e.reg_t), 32'(reg_t));
            end
        end
    endtask

    // back to back, each result checked the cycle after its word
    task automatic stream_words(input string name);
        for (int i = 0; i < word_q.size(); i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            inst     <= word_q[i];
            if (i > 0) begin
                @(negedge clk);
                check_result($sformatf("%s 0x%08h", name, word_q[i-1]),
                             ref_decode(word_q[i-1]));
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_result($sformatf("%s 0x%08h", name, word_q[$]), ref_decode(word_q[$]));
        word_q.delete();
    endtask

    task automatic reset_values();
        expect_eq("reset_values", "out_valid", 32'(0), 32'(out_valid));
        expect_eq("reset_values", "invalid", 32'(0), 32'(invalid));
        expect_eq("reset_values", "op", 32'(OP_INVALID), 32'(op));
    endtask

    task automatic rtype_table();
        foreach (SPECIAL_FN[i])
            word_q.push_back({SPECIAL, 20'($urandom), SPECIAL_FN[i]});  // rs rt rd shamt random
        foreach (SPECIAL2_FN[i])
            word_q.push_back({SPECIAL2, 20'($urandom), SPECIAL2_FN[i]});
        stream_words("rtype_table");
    endtask

    task automatic imm_forms();
        logic [31:0] w;
        foreach (IMM_OPC[i]) begin
            for (int k = 0; k < 2; k++) begin
                w     = {IMM_OPC[i], 26'($urandom)};
                w[15] = k[0];                       // both signs of imm16
                word_q.push_back(w);
            end
        end
        stream_words("imm_forms");
    endtask

    task automatic branches_jumps();
        word_q.push_back({6'h04, 26'($urandom)});
        foreach (REGIMM_RT[i])
            word_q.push_back({REGIMM, 5'($urandom), REGIMM_RT[i], 16'($urandom)});
        word_q.push_back({6'h02, 26'($urandom)});
        word_q.push_back({6'h02, 26'h2000001});     // top index bit set
        word_q.push_back({6'h03, 26'($urandom)});
        stream_words("branches_jumps");
    endtask

    task automatic invalid_words();
        word_q.push_back({6'h10, 26'($urandom)});   // cop0
        word_q.push_back({6'h11, 26'($urandom)});
        word_q.push_back({6'h22, 26'($urandom)});
        word_q.push_back({6'h3f, 26'($urandom)});
        word_q.push_back({SPECIAL, 20'($urandom), 6'h01});
        word_q.push_back({SPECIAL, 20'($urandom), 6'h0d});
        word_q.push_back({SPECIAL, 20'($urandom), 6'h30});
        word_q.push_back({SPECIAL2, 20'($urandom), 6'h03});
        word_q.push_back({SPECIAL2, 20'($urandom), 6'h3f});
        word_q.push_back({REGIMM, 5'($urandom), 5'h02, 16'($urandom)});
        word_q.push_back({REGIMM, 5'($urandom), 5'h12, 16'($urandom)});
        stream_words("invalid_words");
    endtask

    task automatic stall_and_flush();
        exp_t        pending [$];
        logic [31:0] cur;
        int          sent;
        int          got;
        int          k;
        sent = 0;
        got  = 0;
        k    = int'($urandom % 12);
        cur  = {STREAM_OPC[k], 26'($urandom)};
        while (got < STREAM_WORDS) begin
            @(posedge clk);
            if (in_valid && !stall) begin           // taken at this edge
                pending.push_back(ref_decode(inst));
                sent++;
                k   = int'($urandom % 12);
                cur = {STREAM_OPC[k], 26'($urandom)};
            end
            stall    <= ($urandom % 3 == 0);
            in_valid <= (sent < STREAM_WORDS);
            inst     <= cur;
            @(negedge clk);
            if (out_valid && !stall) begin          // downstream takes it next edge
                if (pending.size() == 0) begin
                    $display("stall_and_flush: result appeared with no word pending");
                    errors++;
                end else begin
                    check_result("stall_and_flush", pending.pop_front());
                end
                got++;
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        assert (!out_valid && pending.size() == 0) else begin
            $display("stall_and_flush: extra or missing results after the stream");
            errors++;
        end
        // word arriving together with flush
        @(posedge clk);
        in_valid <= 1'b1;
        inst     <= cur;
        flush    <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b0;
        @(negedge clk);
        assert (!out_valid) else begin
            $display("stall_and_flush: word sent with flush came out anyway");
            errors++;
        end
        // result already out, then flushed while stalled
        @(posedge clk);
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b1;
        stall    <= 1'b1;
        @(negedge clk);
        assert (out_valid) else begin
            $display("stall_and_flush: word before the flush gave no result");
            errors++;
        end
        @(posedge clk);
        flush    <= 1'b0;
        stall    <= 1'b0;
        @(negedge clk);
        assert (!out_valid) else begin
            $display("stall_and_flush: flush did not clear the pending result");
            errors++;
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        inst     = 32'd0;
        stall    = 1'b0;
        flush    = 1'b0;
        void'($urandom(28774));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_values();
        rtype_table();
        imm_forms();
        branches_jumps();
        invalid_words();
        stall_and_flush();
        errors += dut.u_id_stage.u_chk.fails;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
